// ==== logic/cpu_pkg.sv ====
/*
 * shared widths and types of the core
 * opcode, function and alu operation codes
 * reset address, register count, debug write enable
 */

package cpu_pkg;

    typedef logic [31:0] word_t;       // data word, pc or instruction
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    typedef enum logic [1:0] {
        CTRL_RUN,
        CTRL_DRAIN,
        CTRL_HALTED
    } ctrl_state_t;

    localparam alu_op_t ALU_ADD = 4'h0;
    localparam alu_op_t ALU_SUB = 4'h1;
    localparam alu_op_t ALU_AND = 4'h2;
    localparam alu_op_t ALU_OR  = 4'h3;
    localparam alu_op_t ALU_XOR = 4'h4;
    localparam alu_op_t ALU_SLT = 4'h5;
    localparam alu_op_t ALU_LUI = 4'h6;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function field of SPECIAL
    localparam logic [5:0] FN_BREAK = 6'h0d;   // used as halt
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    localparam word_t      RESET_PC = 32'h0000_0000;
    localparam int         NUM_REGS = 32;
    localparam logic [3:0] WEN_ALL  = 4'b1111;

endpackage

// ==== logic/stage_ctrl_if.sv ====
/*
 * pipeline control bundle
 * branch and halt status from execute, pc write and flushes from control
 */

`timescale 1ns/1ps

interface stage_ctrl_if import cpu_pkg::*; ();

    logic  branch_taken;
    word_t branch_target;
    logic  halt_seen;
    logic  pc_wr;
    logic  pc_redirect;
    logic  id_flush;       // bubble into fetch/decode register
    logic  exe_flush;      // bubble into decode/execute register

    modport ctrl (
        input  branch_taken, branch_target, halt_seen,
        output pc_wr, pc_redirect, id_flush, exe_flush
    );

    modport fetch (input pc_wr, pc_redirect, id_flush, branch_target);

    modport decode (input exe_flush);

    modport execute (output branch_taken, branch_target, halt_seen);

endinterface

// ==== logic/pipeline_control.sv ====
/*
 * run/drain/halted state machine
 * pc write, redirect and flush strobes for all stages
 */

`timescale 1ns/1ps

module pipeline_control import cpu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          inst_busy,
    stage_ctrl_if.ctrl    ctrl,
    output logic          halted
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // outside RUN the pc holds and both stage registers take bubbles
    always_comb begin
        state_nxt        = state;
        ctrl.pc_wr       = 1'b0;
        ctrl.pc_redirect = 1'b0;
        ctrl.id_flush    = 1'b1;
        ctrl.exe_flush   = 1'b1;
        case (state)
            CTRL_RUN: begin
                if (ctrl.halt_seen) begin
                    state_nxt = CTRL_DRAIN;     // drop everything behind the halt
                end else begin
                    ctrl.pc_redirect = ctrl.branch_taken;
                    ctrl.pc_wr       = ctrl.branch_taken | ~inst_busy;
                    ctrl.id_flush    = inst_busy | ctrl.branch_taken;
                    ctrl.exe_flush   = ctrl.branch_taken;
                end
            end
            CTRL_DRAIN: state_nxt = CTRL_HALTED;
            default: state_nxt = state;         // halted until reset
        endcase
    end

    assign halted = (state == CTRL_HALTED);

endmodule

// ==== logic/fetch_stage.sv ====
/*
 * program counter and next pc select
 * fetch/decode pipeline register
 */

`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    stage_ctrl_if.fetch   ctrl,
    output word_t         inst_addr,
    input  word_t         inst_rdata,
    output word_t         id_pc,
    output word_t         id_instr,
    output logic          id_valid
);

    word_t pc;
    word_t pc_next;

    // predict not taken, execute redirects on a taken branch
    assign pc_next   = ctrl.pc_redirect ? ctrl.branch_target : pc + 32'd4;
    assign inst_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (ctrl.pc_wr) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= ~ctrl.id_flush;     // busy word or wrong path becomes a bubble
        end
    end

    // word and its pc only matter while id_valid is set
    always_ff @(posedge clk) begin
        if (!ctrl.id_flush) begin
            id_pc    <= pc;
            id_instr <= inst_rdata;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
/*
 * 32 x 32 register file
 * two read ports, one write port, write-first bypass
 */

`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  reg_addr_t  rs_addr,
    input  reg_addr_t  rt_addr,
    output word_t      rs_data,
    output word_t      rt_data,
    input  logic       wr_en,
    input  reg_addr_t  wr_addr,
    input  word_t      wr_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // a read of the register being written sees the new value
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

// ==== logic/decode_stage.sv ====
/*
 * instruction decoder and immediate extension
 * register reads and the decode/execute pipeline register
 */

`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    stage_ctrl_if.decode  ctrl,
    input  word_t         id_pc,
    input  word_t         id_instr,
    input  logic          id_valid,
    output logic          ex_valid,
    output word_t         ex_pc,
    output alu_op_t       ex_alu_op,
    output word_t         ex_src_a,
    output word_t         ex_src_b,
    output reg_addr_t     ex_rs,
    output reg_addr_t     ex_rt,
    output logic          ex_use_imm,
    output word_t         ex_imm,
    output reg_addr_t     ex_dst,
    output logic          ex_reg_wr,
    output logic          ex_is_beq,
    output logic          ex_is_bne,
    output logic          ex_is_halt,
    input  logic          wb_wr_en,
    input  reg_addr_t     wb_wr_addr,
    input  word_t         wb_wr_data
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    alu_op_t    alu_op;
    reg_addr_t  dst;
    logic       reg_wr;
    logic       use_imm;
    logic       sign_ext;
    logic       is_beq;
    logic       is_bne;
    logic       is_halt;
    word_t      imm_ext;
    word_t      rs_data;
    word_t      rt_data;

    assign opcode = id_instr[31:26];
    assign rs     = id_instr[25:21];
    assign rt     = id_instr[20:16];
    assign rd     = id_instr[15:11];
    assign funct  = id_instr[5:0];

    always_comb begin
        alu_op   = ALU_ADD;
        dst      = rd;
        reg_wr   = 1'b0;
        use_imm  = 1'b0;
        sign_ext = 1'b1;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_halt  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                reg_wr = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_BREAK: begin
                        reg_wr  = 1'b0;
                        is_halt = 1'b1;
                    end
                    default: reg_wr = 1'b0;     // unknown function runs as nop
                endcase
            end
            OP_ADDIU: begin
                dst     = rt;
                reg_wr  = 1'b1;
                use_imm = 1'b1;
            end
            OP_ORI, OP_LUI: begin
                alu_op   = (opcode == OP_LUI) ? ALU_LUI : ALU_OR;
                dst      = rt;
                reg_wr   = 1'b1;
                use_imm  = 1'b1;
                sign_ext = 1'b0;
            end
            OP_BEQ: is_beq = 1'b1;
            OP_BNE: is_bne = 1'b1;
            default: reg_wr = 1'b0;
        endcase
    end

    assign imm_ext = sign_ext ? {{16{id_instr[15]}}, id_instr[15:0]} : {16'h0, id_instr[15:0]};

    reg_file rf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wb_wr_en),
        .wr_addr (wb_wr_addr),
        .wr_data (wb_wr_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            ex_reg_wr  <= 1'b0;
            ex_is_beq  <= 1'b0;
            ex_is_bne  <= 1'b0;
            ex_is_halt <= 1'b0;
        end else if (ctrl.exe_flush) begin
            ex_valid   <= 1'b0;
            ex_reg_wr  <= 1'b0;
            ex_is_beq  <= 1'b0;
            ex_is_bne  <= 1'b0;
            ex_is_halt <= 1'b0;
        end else begin
            ex_valid   <= id_valid;
            ex_reg_wr  <= reg_wr & id_valid & (dst != '0);   // $zero never retires
            ex_is_beq  <= is_beq;
            ex_is_bne  <= is_bne;
            ex_is_halt <= is_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= id_pc;
        ex_alu_op  <= alu_op;
        ex_src_a   <= rs_data;
        ex_src_b   <= rt_data;
        ex_rs      <= rs;
        ex_rt      <= rt;
        ex_use_imm <= use_imm;
        ex_imm     <= imm_ext;
        ex_dst     <= dst;
    end

endmodule

// ==== logic/execute_stage.sv ====
/*
 * operand forwarding, alu and branch resolution
 * halt detection and the writeback register
 */

`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    stage_ctrl_if.execute  ctrl,
    input  logic           ex_valid,
    input  word_t          ex_pc,
    input  alu_op_t        ex_alu_op,
    input  word_t          ex_src_a,
    input  word_t          ex_src_b,
    input  reg_addr_t      ex_rs,
    input  reg_addr_t      ex_rt,
    input  logic           ex_use_imm,
    input  word_t          ex_imm,
    input  reg_addr_t      ex_dst,
    input  logic           ex_reg_wr,
    input  logic           ex_is_beq,
    input  logic           ex_is_bne,
    input  logic           ex_is_halt,
    output logic           wb_wr_en,
    output reg_addr_t      wb_wr_addr,
    output word_t          wb_wr_data,
    output word_t          wb_pc
);

    word_t op_a;
    word_t op_rt;
    word_t op_b;
    word_t alu_res;
    logic  operands_eq;

    // only the previous instruction can be missing from the register file
    assign op_a = (wb_wr_en && wb_wr_addr == ex_rs) ? wb_wr_data : ex_src_a;
    assign op_rt = (wb_wr_en && wb_wr_addr == ex_rt) ? wb_wr_data : ex_src_b;
    assign op_b = ex_use_imm ? ex_imm : op_rt;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
            ALU_LUI: alu_res = {op_b[15:0], 16'h0};
            default: alu_res = op_a + op_b;
        endcase
    end

    assign operands_eq = (op_a == op_rt);

    assign ctrl.branch_taken  = ex_valid &
                                ((ex_is_beq & operands_eq) | (ex_is_bne & ~operands_eq));
    assign ctrl.branch_target = ex_pc + 32'd4 + {ex_imm[29:0], 2'b00};   // no delay slot
    assign ctrl.halt_seen     = ex_valid & ex_is_halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_wr_en <= 1'b0;
        end else begin
            wb_wr_en <= ex_reg_wr;      // already cleared for bubbles
        end
    end

    always_ff @(posedge clk) begin
        wb_wr_addr <= ex_dst;
        wb_wr_data <= alu_res;
        wb_pc      <= ex_pc;
    end

endmodule

// ==== logic/cpu_core.sv ====
/*
 * core top level
 * fetch, decode, execute and the pipeline control
 * golden trace debug outputs at writeback
 */

`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output word_t      inst_addr,
    input  word_t      inst_rdata,
    input  logic       inst_busy,
    output logic       halted,
    output word_t      debug_wb_pc,
    output word_t      debug_wb_rf_wdata,
    output logic [3:0] debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum
);

    word_t     id_pc;
    word_t     id_instr;
    logic      id_valid;
    logic      ex_valid;
    word_t     ex_pc;
    alu_op_t   ex_alu_op;
    word_t     ex_src_a;
    word_t     ex_src_b;
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    logic      ex_use_imm;
    word_t     ex_imm;
    reg_addr_t ex_dst;
    logic      ex_reg_wr;
    logic      ex_is_beq;
    logic      ex_is_bne;
    logic      ex_is_halt;
    logic      wb_wr_en;
    reg_addr_t wb_wr_addr;
    word_t     wb_wr_data;
    word_t     wb_pc;

    stage_ctrl_if ctrl_bus ();

    pipeline_control control_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_busy (inst_busy),
        .ctrl      (ctrl_bus.ctrl),
        .halted    (halted)
    );

    fetch_stage fetch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.fetch),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .id_pc      (id_pc),
        .id_instr   (id_instr),
        .id_valid   (id_valid)
    );

    decode_stage decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.decode),
        .id_pc      (id_pc),
        .id_instr   (id_instr),
        .id_valid   (id_valid),
        .ex_valid   (ex_valid),
        .ex_pc      (ex_pc),
        .ex_alu_op  (ex_alu_op),
        .ex_src_a   (ex_src_a),
        .ex_src_b   (ex_src_b),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_use_imm (ex_use_imm),
        .ex_imm     (ex_imm),
        .ex_dst     (ex_dst),
        .ex_reg_wr  (ex_reg_wr),
        .ex_is_beq  (ex_is_beq),
        .ex_is_bne  (ex_is_bne),
        .ex_is_halt (ex_is_halt),
        .wb_wr_en   (wb_wr_en),
        .wb_wr_addr (wb_wr_addr),
        .wb_wr_data (wb_wr_data)
    );

    execute_stage execute_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.execute),
        .ex_valid   (ex_valid),
        .ex_pc      (ex_pc),
        .ex_alu_op  (ex_alu_op),
        .ex_src_a   (ex_src_a),
        .ex_src_b   (ex_src_b),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_use_imm (ex_use_imm),
        .ex_imm     (ex_imm),
        .ex_dst     (ex_dst),
        .ex_reg_wr  (ex_reg_wr),
        .ex_is_beq  (ex_is_beq),
        .ex_is_bne  (ex_is_bne),
        .ex_is_halt (ex_is_halt),
        .wb_wr_en   (wb_wr_en),
        .wb_wr_addr (wb_wr_addr),
        .wb_wr_data (wb_wr_data),
        .wb_pc      (wb_pc)
    );

    // trace shows the write that lands in the register file this cycle
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_wr_data;
    assign debug_wb_rf_wen   = wb_wr_en ? WEN_ALL : 4'b0000;
    assign debug_wb_rf_wnum  = wb_wr_addr;

endmodule

// ==== tests/cpu_core_assertions.sv ====
/*
 * concurrent checks on the core ports
 * bound into cpu_core
 */

`timescale 1ns/1ps

module cpu_core_assertions import cpu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       halted,
    input logic [3:0] debug_wb_rf_wen,
    input reg_addr_t  debug_wb_rf_wnum
);

    int failures = 0;

    // halted is sticky until the next reset
    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else begin
            $error("halted fell without a reset");
            failures++;
        end

    no_zero_write: assert property (@(posedge clk) disable iff (!rst_n)
        (debug_wb_rf_wen != 4'b0000) |-> (debug_wb_rf_wnum != '0))
        else begin
            $error("a write to register zero showed up on the trace port");
            failures++;
        end

    // writeback is empty once halted has been high for a cycle
    quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        (halted && $past(halted)) |-> (debug_wb_rf_wen == 4'b0000))
        else begin
            $error("a write retired after the core halted");
            failures++;
        end

endmodule

bind cpu_core cpu_core_assertions assertions_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .halted           (halted),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

// ==== tests/cpu_core_tb.sv ====
/*
 * testbench of the core: clock, reset, instruction memory model
 * random fetch busy and golden trace checking from the test data file
 */

`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

    logic        clk;
    logic        rst_n;
    word_t       inst_addr;
    word_t       inst_rdata;
    logic        inst_busy;
    logic        halted;
    word_t       debug_wb_pc;
    word_t       debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    reg_addr_t   debug_wb_rf_wnum;

    word_t       tdata [256];      // raw words of the data file
    word_t       imem [64];
    word_t       exp_pc [32];
    reg_addr_t   exp_num [32];
    word_t       exp_data [32];
    int          trace_len;
    logic        busy_random;
    logic [31:0] rnd_state;
    int          errors;
    int          tests_run;
    int          tests_failed;

    cpu_core dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .inst_busy         (inst_busy),
        .halted            (halted),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // opcode 3f decodes as a nop, the rest folds in the whole address
    function automatic word_t fill_word(word_t addr);
        return {6'h3f, addr[31:6] ^ addr[25:0]};
    endfunction

    function automatic logic [31:0] next_random(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory answers in the same cycle
    assign inst_rdata = (inst_addr < 32'd256) ? imem[inst_addr[7:2]] : fill_word(inst_addr);

    always @(posedge clk) begin
        if (busy_random) begin
            rnd_state = next_random(rnd_state);
            inst_busy <= (rnd_state[1:0] == 2'b00);    // about one cycle in four
        end else begin
            inst_busy <= 1'b0;
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic load_testdata();
        int n;
        int base;
        $readmemh("tests/cpu_testdata.txt", tdata);
        for (int i = 0; i < 64; i++) begin
            imem[i] = fill_word(word_t'(i * 4));
        end
        trace_len = 0;
        if ($isunknown(tdata[0])) begin
            $display("the test data file could not be read");
            errors++;
        end else begin
            n = tdata[0];
            for (int i = 0; i < n; i++) begin
                imem[tdata[1 + 2 * i][7:2]] = tdata[2 + 2 * i];
            end
            base = 1 + 2 * n;
            trace_len = tdata[base];
            for (int i = 0; i < trace_len; i++) begin
                exp_pc[i]   = tdata[base + 1 + 3 * i];
                exp_num[i]  = tdata[base + 2 + 3 * i][4:0];
                exp_data[i] = tdata[base + 3 + 3 * i];
            end
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("halted in reset", halted, 1'b0);
        check_flag("trace write in reset", |debug_wb_rf_wen, 1'b0);
        check_word("inst_addr in reset", inst_addr, RESET_PC);
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_program(input string name);
        int idx;
        int cycles;
        int err_start;
        err_start = errors;
        idx = 0;
        cycles = 0;
        // retired writes in order until halted, bounded by a cycle budget
        while (!halted && cycles < 400) begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_wen != 4'b0000) begin
                if (idx < trace_len) begin
                    check_word("retired pc", debug_wb_pc, exp_pc[idx]);
                    check_reg("retired register", debug_wb_rf_wnum, exp_num[idx]);
                    check_word("retired data", debug_wb_rf_wdata, exp_data[idx]);
                    check_flag("all byte enables", debug_wb_rf_wen == WEN_ALL, 1'b1);
                end else begin
                    $display("write to r%0d from pc %h retired after the expected trace ended",
                             debug_wb_rf_wnum, debug_wb_pc);
                    errors++;
                end
                idx++;
            end
        end
        if (!halted) begin
            $display("timeout: halted did not rise within 400 cycles in run %s", name);
            errors++;
        end
        if (idx != trace_len) begin
            $display("run %s retired %0d writes, the trace has %0d", name, idx, trace_len);
            errors++;
        end
        report_test({name, ": alu, forwarding and branch trace"}, err_start);
        err_start = errors;
        repeat (20) begin
            @(negedge clk);
            check_flag("halted level", halted, 1'b1);
            check_flag("trace write while halted", |debug_wb_rf_wen, 1'b0);
        end
        report_test({name, ": halt"}, err_start);
    endtask

    initial begin
        int err_start;
        rst_n = 1'b0;
        inst_busy = 1'b0;
        busy_random = 1'b0;
        rnd_state = 32'h1edf;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        load_testdata();
        err_start = errors;
        reset_dut();
        report_test("reset state", err_start);
        run_program("no busy");
        busy_random = 1'b1;
        err_start = errors;
        reset_dut();
        report_test("reset after halt", err_start);
        run_program("random busy");
        $display("tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut_i.assertions_i.failures);
        if (errors == 0 && dut_i.assertions_i.failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/cpu_testdata.txt ====
// program: word count, then one line per word with address and instruction
// trace: entry count, then pc, register number and data of each retired write
00000015
00000000 3c011234   // lui   r1, 0x1234
00000004 34215678   // ori   r1, r1, 0x5678
00000008 2402fffd   // addiu r2, r0, -3
0000000c 00221821   // addu  r3, r1, r2
00000010 00612023   // subu  r4, r3, r1
00000014 0080282a   // slt   r5, r4, r0
00000018 24a00007   // addiu r0, r5, 7
0000001c 00a33026   // xor   r6, r5, r3
00000020 10c60002   // beq   r6, r6, 0x2c
00000024 24070bad   // skipped
00000028 24070bad   // skipped
0000002c 00c13824   // and   r7, r6, r1
00000030 14a50001   // bne   r5, r5, not taken
00000034 00e24025   // or    r8, r7, r2
00000038 15070002   // bne   r8, r7, 0x44
0000003c 24090bad   // skipped
00000040 24090bad   // skipped
00000044 01074821   // addu  r9, r8, r7
00000048 0000000d   // break, halts the core
0000004c 240a0bad   // never retires
00000050 240a0bad   // never retires
0000000a
00000000 00000001 12340000
00000004 00000001 12345678
00000008 00000002 fffffffd
0000000c 00000003 12345675
00000010 00000004 fffffffd
00000014 00000005 00000001
0000001c 00000006 12345674
0000002c 00000007 12345670
00000034 00000008 fffffffd
00000044 00000009 1234566d

// ==== src.f ====
logic/cpu_pkg.sv
logic/stage_ctrl_if.sv
logic/pipeline_control.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/cpu_core.sv
tests/cpu_core_assertions.sv
tests/cpu_core_tb.sv
